// ==== files.f ====
hw/snn_pkg.sv
hw/param_regs.sv
hw/lif_neuron.sv
hw/stdp_synapse.sv
hw/spike_monitor.sv
hw/snn_top.sv
test/snn_checker.sv
test/tb_snn_top.sv

// ==== hw/lif_neuron.sv ====
`default_nettype none

module lif_neuron #(
    parameter int LEAK_SHIFT = 3
) (
    input  wire                 ep50trig,
    input  wire                 reset_global,
    input  wire                 i_clear,
    input  wire snn_pkg::word_t i_current,
    output logic                o_spike
);
    import snn_pkg::*;

    word_t       v;       // membrane potential, x1024
    logic [32:0] v_cand;  // one extra bit so a big input cannot wrap
    logic        fire;

    // integrate, then leak a fraction of the old potential
    // v >> LEAK_SHIFT never exceeds v, so no underflow
    assign v_cand = {1'b0, v} + {1'b0, i_current} - {1'b0, v >> LEAK_SHIFT};

    assign fire = (v_cand >= {1'b0, TH_SCALED});

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            v       <= '0;
            o_spike <= 1'b0;
        end
        else if (i_clear)
        begin
            v       <= '0;   // held at rest during sim clear
            o_spike <= 1'b0;
        end
        else if (fire)
        begin
            v       <= '0;   // reset to rest after firing
            o_spike <= 1'b1;
        end
        else
        begin
            // below threshold so upper bit is zero
            v       <= v_cand[31:0];
            o_spike <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/param_regs.sv ====
`default_nettype none

module param_regs (
    input  wire                     ep50trig,
    input  wire                     reset_global,
    input  wire                     i_cfg_req,
    input  wire snn_pkg::cfg_addr_t i_cfg_addr,
    input  wire snn_pkg::word_t     i_cfg_data,
    output logic                    o_cfg_ack,
    output snn_pkg::word_t          o_drive0,
    output snn_pkg::word_t          o_drive2,
    output snn_pkg::word_t          o_ltp,
    output snn_pkg::word_t          o_ltd,
    output snn_pkg::word_t          o_ctrl
);
    import snn_pkg::*;

    logic wr_en; // req seen, not yet acked

    // one write per request, ack low means this req is new
    assign wr_en = i_cfg_req & ~o_cfg_ack;

    // ack follows req one edge later in both directions
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_cfg_ack <= 1'b0;
        else if (wr_en)
            o_cfg_ack <= 1'b1;      // write edge
        else if (!i_cfg_req)
            o_cfg_ack <= 1'b0;      // host released req
    end

    // config registers
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_drive0 <= DRIVE_RESET;
            o_drive2 <= DRIVE_RESET;
            o_ltp    <= LTP_RESET;
            o_ltd    <= LTD_RESET;
            o_ctrl   <= CTRL_RESET;
        end
        else if (wr_en)
        begin
            case (i_cfg_addr)
                REG_DRIVE0:
                    o_drive0 <= i_cfg_data;
                REG_DRIVE2:
                    o_drive2 <= i_cfg_data;
                REG_LTP:
                    o_ltp <= i_cfg_data;
                REG_LTD:
                    o_ltd <= i_cfg_data;
                REG_CTRL:
                    o_ctrl <= i_cfg_data;   // takes effect next edge
                default:
                    ;                       // unmapped, ack only
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/snn_pkg.sv ====
`default_nettype none

package snn_pkg;

    typedef logic [31:0] word_t;      // currents, weights, counts, reg data
    typedef logic [2:0]  cfg_addr_t;  // host write address
    typedef logic [2:0]  stat_addr_t; // status read address

    // host register map
    localparam cfg_addr_t REG_DRIVE0 = 3'd0; // neuron 0 drive
    localparam cfg_addr_t REG_DRIVE2 = 3'd1; // neuron 2 drive
    localparam cfg_addr_t REG_LTP    = 3'd2; // potentiation step
    localparam cfg_addr_t REG_LTD    = 3'd3; // depression step
    localparam cfg_addr_t REG_CTRL   = 3'd4;

    // control word bit positions
    localparam int CTRL_BLOCK0    = 0; // zero input to neuron 0
    localparam int CTRL_BLOCK2    = 1; // zero input to neuron 2
    localparam int CTRL_CUT1      = 2; // s1 presyn spikes masked
    localparam int CTRL_CUT2      = 3; // s2 presyn spikes masked
    localparam int CTRL_SYNC      = 4; // n2 takes drive0
    localparam int CTRL_SIM_CLEAR = 5; // hold network in reset state

    // register reset values
    localparam word_t DRIVE_RESET = 32'd10240; // 10 x 1024
    localparam word_t LTP_RESET   = 32'd2;
    localparam word_t LTD_RESET   = 32'd1;
    localparam word_t CTRL_RESET  = 32'd0;

    // 30 mV threshold, x1024 fixed point
    localparam word_t TH_SCALED = 32'd30720;

    // status map, counts then weights
    localparam stat_addr_t STAT_COUNT_BASE  = 3'd0;
    localparam stat_addr_t STAT_WEIGHT_BASE = 3'd4;

    localparam int NUM_NEURONS = 4;

endpackage

`default_nettype wire

// ==== hw/snn_top.sv ====
`default_nettype none

module snn_top #(
    parameter int             LEAK_SHIFT  = 3,
    parameter int             STDP_WINDOW = 16,
    parameter snn_pkg::word_t W_MAX       = 32'd65535,
    parameter snn_pkg::word_t BASE_W0     = 32'd20480, // n0 -> n1, strong
    parameter snn_pkg::word_t BASE_W1     = 32'd5120,  // n0 -> n3, crosstalk
    parameter snn_pkg::word_t BASE_W2     = 32'd5120,  // n2 -> n1, crosstalk
    parameter snn_pkg::word_t BASE_W3     = 32'd20480  // n2 -> n3, strong
) (
    input  wire                            ep50trig,
    input  wire                            reset_global,
    input  wire                            i_cfg_req,
    input  wire snn_pkg::cfg_addr_t        i_cfg_addr,
    input  wire snn_pkg::word_t            i_cfg_data,
    output wire                            o_cfg_ack,
    input  wire snn_pkg::stat_addr_t       i_stat_addr,
    output wire snn_pkg::word_t            o_stat_data,
    output wire [snn_pkg::NUM_NEURONS-1:0] o_spike
);
    import snn_pkg::*;

    word_t drive0, drive2, ltp, ltd, ctrl;   // from host regs
    word_t n2_src;                           // drive2 or drive0 under sync
    word_t in_n0, in_n1, in_n2, in_n3;       // neuron input currents
    word_t cur_s0, cur_s1, cur_s2, cur_s3;   // synaptic currents
    word_t w_s0, w_s1, w_s2, w_s3;           // synaptic weights
    logic  spike0, spike1, spike2, spike3;
    logic  pre_s1, pre_s2;                   // presyn after cut mask
    logic  sim_clear;

    param_regs regs_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_cfg_req    (i_cfg_req),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_data   (i_cfg_data),
        .o_cfg_ack    (o_cfg_ack),
        .o_drive0     (drive0),
        .o_drive2     (drive2),
        .o_ltp        (ltp),
        .o_ltd        (ltd),
        .o_ctrl       (ctrl)
    );

    assign sim_clear = ctrl[CTRL_SIM_CLEAR];

    // input selection
    assign in_n0  = ctrl[CTRL_BLOCK0] ? '0 : drive0;
    assign n2_src = ctrl[CTRL_SYNC] ? drive0 : drive2;   // same drive on both
    assign in_n2  = ctrl[CTRL_BLOCK2] ? '0 : n2_src;
    assign pre_s1 = ctrl[CTRL_CUT1] ? 1'b0 : spike0;
    assign pre_s2 = ctrl[CTRL_CUT2] ? 1'b0 : spike2;

    // weights stay under W_MAX so the sums cannot wrap
    assign in_n1 = cur_s0 + cur_s2;
    assign in_n3 = cur_s1 + cur_s3;

    lif_neuron #(.LEAK_SHIFT(LEAK_SHIFT)) neuron0 (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_clear (sim_clear),
        .i_current (in_n0), .o_spike (spike0)
    );
    lif_neuron #(.LEAK_SHIFT(LEAK_SHIFT)) neuron1 (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_clear (sim_clear),
        .i_current (in_n1), .o_spike (spike1)
    );
    lif_neuron #(.LEAK_SHIFT(LEAK_SHIFT)) neuron2 (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_clear (sim_clear),
        .i_current (in_n2), .o_spike (spike2)
    );
    lif_neuron #(.LEAK_SHIFT(LEAK_SHIFT)) neuron3 (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_clear (sim_clear),
        .i_current (in_n3), .o_spike (spike3)
    );

    // s0: n0 -> n1
    stdp_synapse #(.BASE_WEIGHT(BASE_W0), .STDP_WINDOW(STDP_WINDOW), .W_MAX(W_MAX)) synapse0 (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_clear (sim_clear),
        .i_pre_spike (spike0), .i_post_spike (spike1), .i_ltp (ltp), .i_ltd (ltd),
        .o_current (cur_s0), .o_weight (w_s0)
    );
    // s1: n0 -> n3, cuttable
    stdp_synapse #(.BASE_WEIGHT(BASE_W1), .STDP_WINDOW(STDP_WINDOW), .W_MAX(W_MAX)) synapse1 (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_clear (sim_clear),
        .i_pre_spike (pre_s1), .i_post_spike (spike3), .i_ltp (ltp), .i_ltd (ltd),
        .o_current (cur_s1), .o_weight (w_s1)
    );
    // s2: n2 -> n1, cuttable
    stdp_synapse #(.BASE_WEIGHT(BASE_W2), .STDP_WINDOW(STDP_WINDOW), .W_MAX(W_MAX)) synapse2 (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_clear (sim_clear),
        .i_pre_spike (pre_s2), .i_post_spike (spike1), .i_ltp (ltp), .i_ltd (ltd),
        .o_current (cur_s2), .o_weight (w_s2)
    );
    // s3: n2 -> n3
    stdp_synapse #(.BASE_WEIGHT(BASE_W3), .STDP_WINDOW(STDP_WINDOW), .W_MAX(W_MAX)) synapse3 (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_clear (sim_clear),
        .i_pre_spike (spike2), .i_post_spike (spike3), .i_ltp (ltp), .i_ltd (ltd),
        .o_current (cur_s3), .o_weight (w_s3)
    );

    spike_monitor monitor_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_clear      (sim_clear),
        .i_spike      ({spike3, spike2, spike1, spike0}),
        .i_w0         (w_s0),
        .i_w1         (w_s1),
        .i_w2         (w_s2),
        .i_w3         (w_s3),
        .i_stat_addr  (i_stat_addr),
        .o_stat_data  (o_stat_data)
    );

    assign o_spike = {spike3, spike2, spike1, spike0};  // raw registered spikes

endmodule

`default_nettype wire

// ==== hw/spike_monitor.sv ====
`default_nettype none

module spike_monitor (
    input  wire                              ep50trig,
    input  wire                              reset_global,
    input  wire                              i_clear,
    input  wire [snn_pkg::NUM_NEURONS-1:0]   i_spike,
    input  wire snn_pkg::word_t              i_w0,
    input  wire snn_pkg::word_t              i_w1,
    input  wire snn_pkg::word_t              i_w2,
    input  wire snn_pkg::word_t              i_w3,
    input  wire snn_pkg::stat_addr_t         i_stat_addr,
    output snn_pkg::word_t                   o_stat_data
);
    import snn_pkg::*;

    word_t      count [NUM_NEURONS];   // spikes per neuron
    word_t      weight [NUM_NEURONS];  // s0..s3
    stat_addr_t rel_addr;              // offset within count or weight block
    word_t      sel;

    assign weight[0] = i_w0;
    assign weight[1] = i_w1;
    assign weight[2] = i_w2;
    assign weight[3] = i_w3;

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            for (int n = 0; n < NUM_NEURONS; n++)
                count[n] <= '0;
        end
        else if (i_clear)
        begin
            for (int n = 0; n < NUM_NEURONS; n++)
                count[n] <= '0;   // held at zero during sim clear
        end
        else
        begin
            for (int n = 0; n < NUM_NEURONS; n++)
                if (i_spike[n])
                    count[n] <= count[n] + 32'd1;
        end
    end

    // readback select, upper half of the map is weights
    always_comb
    begin
        if (i_stat_addr >= STAT_WEIGHT_BASE)
        begin
            rel_addr = i_stat_addr - STAT_WEIGHT_BASE;
            sel      = weight[rel_addr[1:0]];
        end
        else
        begin
            rel_addr = i_stat_addr - STAT_COUNT_BASE;
            sel      = count[rel_addr[1:0]];
        end
    end

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_stat_data <= '0;
        else
            o_stat_data <= sel;  // valid one cycle after addr
    end

endmodule

`default_nettype wire

// ==== hw/stdp_synapse.sv ====
`default_nettype none

module stdp_synapse #(
    parameter snn_pkg::word_t BASE_WEIGHT = 32'd5120,
    parameter int             STDP_WINDOW = 16,
    parameter snn_pkg::word_t W_MAX       = 32'd65535
) (
    input  wire                 ep50trig,
    input  wire                 reset_global,
    input  wire                 i_clear,
    input  wire                 i_pre_spike,
    input  wire                 i_post_spike,
    input  wire snn_pkg::word_t i_ltp,
    input  wire snn_pkg::word_t i_ltd,
    output snn_pkg::word_t      o_current,
    output snn_pkg::word_t      o_weight
);
    import snn_pkg::*;

    localparam int               AGE_W   = $clog2(STDP_WINDOW + 1);
    localparam logic [AGE_W-1:0] AGE_MAX = AGE_W'(STDP_WINDOW);

    logic [AGE_W-1:0] pre_age;     // cycles since last pre spike, saturates
    logic [AGE_W-1:0] post_age;    // same for post
    logic             pre_recent;
    logic             post_recent;
    logic [32:0]      ltp_sum;     // extra bit for the cap compare
    word_t            w_next;

    // age 1 in the cycle right after a spike
    function automatic logic [AGE_W-1:0] age_step(input logic spike,
                                                  input logic [AGE_W-1:0] age);
        if (spike)
            return AGE_W'(1);
        else if (age < AGE_MAX)
            return age + 1'b1;
        else
            return age;  // stays out of window
    endfunction

    assign pre_recent  = (pre_age < AGE_MAX);
    assign post_recent = (post_age < AGE_MAX);
    assign ltp_sum     = {1'b0, o_weight} + {1'b0, i_ltp};

    // pair-based STDP
    always_comb
    begin
        w_next = o_weight;
        if (i_post_spike && !i_pre_spike && pre_recent)
        begin
            // pre before post, potentiate
            if (ltp_sum > {1'b0, W_MAX})
                w_next = W_MAX;
            else
                w_next = ltp_sum[31:0];
        end
        else if (i_pre_spike && !i_post_spike && post_recent)
        begin
            // post before pre, depress with floor at zero
            if (o_weight > i_ltd)
                w_next = o_weight - i_ltd;
            else
                w_next = '0;
        end
    end

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            pre_age   <= AGE_MAX;
            post_age  <= AGE_MAX;
            o_weight  <= BASE_WEIGHT;
            o_current <= '0;
        end
        else if (i_clear)
        begin
            pre_age   <= AGE_MAX;
            post_age  <= AGE_MAX;
            o_weight  <= BASE_WEIGHT;   // back to baseline strength
            o_current <= '0;
        end
        else
        begin
            pre_age   <= age_step(i_pre_spike, pre_age);
            post_age  <= age_step(i_post_spike, post_age);
            o_weight  <= w_next;
            o_current <= i_pre_spike ? w_next : '0;  // one-cycle current pulse
        end
    end

endmodule

`default_nettype wire

// ==== test/snn_checker.sv ====
`default_nettype none

module snn_checker (
    input wire                     ep50trig,
    input wire                     reset_global,
    input wire                     i_cfg_req,
    input wire snn_pkg::cfg_addr_t i_cfg_addr,
    input wire snn_pkg::word_t     i_cfg_data,
    input wire                     o_cfg_ack
);
    timeunit 1ns;
    timeprecision 100ps;

    // ack only rises in answer to a pending req
    ack_rise_needs_req: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        $rose(o_cfg_ack) |-> $past(i_cfg_req)
    ) else $error("cfg ack rose while req was low");

    // ack drops only once the host let go of req
    ack_fall_needs_idle: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        $fell(o_cfg_ack) |-> !$past(i_cfg_req)
    ) else $error("cfg ack fell while req was still high");

    // addr and data hold until the write edge
    cfg_bus_stable: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (i_cfg_req && !o_cfg_ack) |=>
            (o_cfg_ack || ($stable(i_cfg_addr) && $stable(i_cfg_data)))
    ) else $error("cfg addr or data changed before ack");

    // host keeps req up until it sees ack
    req_held_until_ack: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (i_cfg_req && !o_cfg_ack) |=> (i_cfg_req || o_cfg_ack)
    ) else $error("cfg req dropped before ack");

endmodule

`default_nettype wire

// ==== test/tb_snn_top.sv ====
`default_nettype none

module tb_snn_top;
    timeunit 1ns;
    timeprecision 100ps;

    import snn_pkg::*;

    localparam int    LEAK        = 3;       // leak shift of the reference neuron
    localparam int    ACK_TIMEOUT = 20;      // cycles allowed per handshake phase
    localparam int    RATE_STEPS  = 200;
    localparam word_t W_LIMIT     = 32'd65535;
    localparam word_t BASE_W [4]  = '{32'd20480, 32'd5120, 32'd5120, 32'd20480};
    localparam word_t CLEAR_BIT   = 32'd1 << CTRL_SIM_CLEAR;

    logic                   ep50trig;
    logic                   reset_global;
    logic                   i_cfg_req;
    cfg_addr_t              i_cfg_addr;
    word_t                  i_cfg_data;
    logic                   o_cfg_ack;
    stat_addr_t             i_stat_addr;
    word_t                  o_stat_data;
    logic [NUM_NEURONS-1:0] o_spike;
    logic [31:0]            lfsr_state;   // random source for drive values

    snn_top snn_top_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_cfg_req    (i_cfg_req),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_data   (i_cfg_data),
        .o_cfg_ack    (o_cfg_ack),
        .i_stat_addr  (i_stat_addr),
        .o_stat_data  (o_stat_data),
        .o_spike      (o_spike)
    );

    bind snn_top snn_checker checker_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_cfg_req    (i_cfg_req),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_data   (i_cfg_data),
        .o_cfg_ack    (o_cfg_ack)
    );

    always #5 ep50trig = ~ep50trig;   // 10 ns period

    task automatic fail_run(input string why);
        $display("%s (at %0t ns)", why, $time);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string name, input word_t got, input word_t want);
        assert (got === want)
        else
        begin
            $display("[FAIL] %0t ns %s = %0d, expected %0d", $time, name, got, want);
            fail_run("stopping at the first mismatch");
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1, shift left, feedback into bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random_bits(input int nbits, output word_t value);
        value = '0;
        for (int b = 0; b < nbits; b++)
        begin
            lfsr_state = lfsr_next(lfsr_state);   // one step per bit
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // leaky integrate-and-fire, counted from rest
    function automatic int model_spike_count(input word_t drive, input int steps);
        longint unsigned v;
        longint unsigned cand;
        int              fired;
        v     = 0;
        fired = 0;
        for (int k = 0; k < steps; k++)
        begin
            cand = v + drive - (v >> LEAK);
            if (cand >= 30720)
            begin
                fired++;
                v = 0;   // back to rest
            end
            else
                v = cand;
        end
        return fired;
    endfunction

    // keeps the drive point 1 ns after the edge
    task automatic run_cycles(input int n);
        repeat (n) @(posedge ep50trig);
        #1;
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input word_t data);
        int waited;
        i_cfg_addr = addr;
        i_cfg_data = data;
        i_cfg_req  = 1'b1;
        waited     = 0;
        while (o_cfg_ack !== 1'b1)
        begin
            if (waited == ACK_TIMEOUT)
                fail_run("config write got no acknowledge");
            run_cycles(1);
            waited++;
        end
        i_cfg_req = 1'b0;   // ack seen, release
        waited    = 0;
        while (o_cfg_ack !== 1'b0)
        begin
            if (waited == ACK_TIMEOUT)
                fail_run("config acknowledge never dropped after req was released");
            run_cycles(1);
            waited++;
        end
    endtask

    task automatic stat_read(input stat_addr_t addr, output word_t data);
        i_stat_addr = addr;
        run_cycles(1);          // registered readback, one cycle
        data = o_stat_data;
    endtask

    task automatic reset_and_clear_state();
        word_t value;
        cfg_write(REG_CTRL, CLEAR_BIT);
        for (int n = 0; n < NUM_NEURONS; n++)
        begin
            stat_read(stat_addr_t'(STAT_COUNT_BASE + n), value);
            check_equal($sformatf("count[%0d]", n), value, 32'd0);
            stat_read(stat_addr_t'(STAT_WEIGHT_BASE + n), value);
            check_equal($sformatf("weight[s%0d]", n), value, BASE_W[n]);
        end
    endtask

    task automatic drive_rate_matches_model();
        word_t rnd;
        word_t drive;
        word_t run_bits;
        word_t count0;
        take_random_bits(12, rnd);
        drive    = 32'd4000 + rnd;   // above the 3840 steady-state firing floor
        run_bits = (32'd1 << CTRL_BLOCK2) | (32'd1 << CTRL_CUT1) | (32'd1 << CTRL_CUT2);
        cfg_write(REG_DRIVE0, drive);
        cfg_write(REG_CTRL, run_bits | CLEAR_BIT);
        cfg_write(REG_CTRL, run_bits);   // n0 steps from the edge after this write
        run_cycles(RATE_STEPS);
        stat_read(STAT_COUNT_BASE, count0);
        check_equal("count[0]", count0, word_t'(model_spike_count(drive, RATE_STEPS)));
    endtask

    task automatic block_flags_silence();
        word_t run_bits;
        word_t value;
        run_bits = (32'd1 << CTRL_BLOCK0) | (32'd1 << CTRL_BLOCK2);
        cfg_write(REG_CTRL, run_bits | CLEAR_BIT);
        cfg_write(REG_CTRL, run_bits);
        run_cycles(300);
        for (int n = 0; n < NUM_NEURONS; n++)
        begin
            stat_read(stat_addr_t'(STAT_COUNT_BASE + n), value);
            check_equal($sformatf("count[%0d]", n), value, 32'd0);
        end
    endtask

    task automatic cut_and_weight_bounds();
        word_t run_bits;
        word_t w;
        word_t count3;
        run_bits = 32'd1 << CTRL_CUT1;   // n2 stays on so n3 fires through s3
        cfg_write(REG_LTD, 32'd0);       // no depression at all
        cfg_write(REG_DRIVE0, 32'd10240);
        cfg_write(REG_DRIVE2, 32'd10240);
        cfg_write(REG_CTRL, run_bits | CLEAR_BIT);
        cfg_write(REG_CTRL, run_bits);
        for (int k = 0; k < 40; k++)
        begin
            run_cycles(5);
            stat_read(stat_addr_t'(STAT_WEIGHT_BASE + 1), w);
            check_equal("weight[s1]", w, BASE_W[1]);
            stat_read(STAT_WEIGHT_BASE, w);
            assert (w >= BASE_W[0] && w <= W_LIMIT)
            else
            begin
                $display("[FAIL] %0t ns weight[s0] = %0d, expected %0d..%0d",
                         $time, w, BASE_W[0], W_LIMIT);
                fail_run("stopping at the first mismatch");
            end
        end
        // s1 only potentiates if n3 spiked
        stat_read(stat_addr_t'(STAT_COUNT_BASE + 3), count3);
        assert (count3 != 0)
        else
            fail_run("neuron 3 never fired, so s1 saw no post spikes");
    endtask

    task automatic sync_input_matches();
        word_t run_bits;
        word_t count0;
        word_t count2;
        run_bits = 32'd1 << CTRL_SYNC;   // n2 unblocked, fed from drive0
        cfg_write(REG_DRIVE2, 32'd6000); // slower than drive0, n2 only matches under sync
        cfg_write(REG_CTRL, run_bits | CLEAR_BIT);
        cfg_write(REG_CTRL, run_bits);
        for (int k = 0; k < 150; k++)
        begin
            run_cycles(1);
            check_equal("o_spike[2]", word_t'(o_spike[2]), word_t'(o_spike[0]));
        end
        // freeze both, then compare the settled counts
        cfg_write(REG_CTRL, run_bits | (32'd1 << CTRL_BLOCK0) | (32'd1 << CTRL_BLOCK2));
        run_cycles(2);
        stat_read(STAT_COUNT_BASE, count0);
        stat_read(stat_addr_t'(STAT_COUNT_BASE + 2), count2);
        check_equal("count[2]", count2, count0);
        assert (count0 != 0)
        else
            fail_run("neuron 0 never fired during the sync run");
    endtask

    initial
    begin
        ep50trig     = 1'b0;
        reset_global = 1'b1;
        i_cfg_req    = 1'b0;
        i_cfg_addr   = '0;
        i_cfg_data   = '0;
        i_stat_addr  = '0;
        lfsr_state   = 32'h6dfc48f3;
        run_cycles(8);
        check_equal("o_cfg_ack", word_t'(o_cfg_ack), 32'd0);
        check_equal("o_spike", word_t'(o_spike), 32'd0);
        check_equal("o_stat_data", o_stat_data, 32'd0);
        reset_global = 1'b0;
        reset_and_clear_state();
        drive_rate_matches_model();
        block_flags_silence();
        cut_and_weight_bounds();
        sync_input_matches();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
